/* Bender.yml */
package:
  name: minimig_glue

export_include_dirs:
  - .

sources:
  - minimig_pkg.sv
  - cpu_bus_if.sv
  - cpu_bus_front.sv
  - rtc_port.sv
  - host_config.sv
  - reset_control.sv
  - minimig_glue.sv
  - target: test
    files:
      - tb_minimig_glue.sv

/* cpu_bus_front.sv */
// m68k bus front end for the two register slaves
// address and r_w must be stable while cpu_as_n is low
// writes and unmapped reads are acked locally with zero data
// dtack falls 3 cycles after the strobe is first sampled low
`timescale 1ns/1ns
`include "minimig_glue_settings.svh"

module cpu_bus_front (
	input  logic                clk,
	input  logic                reset,
	input  logic [`ADDR_W:1]    cpu_address,
	input  logic                cpu_as_n,
	input  logic                cpu_r_w,
	output logic [`DATA_W-1:0]  cpu_data,
	output logic                cpu_dtack_n,
	input  logic [2:0]          ipl_n,
	input  logic                int7,
	output logic [2:0]          cpu_ipl_n,
	cpu_bus_if.front            rtc_bus,
	cpu_bus_if.front            cfg_bus
);

	// sequencer states
	localparam logic [1:0] ST_IDLE = 2'd0; // waiting for strobe
	localparam logic [1:0] ST_MISS = 2'd1; // local ack next cycle
	localparam logic [1:0] ST_WAIT = 2'd2; // waiting for an ack
	localparam logic [1:0] ST_HOLD = 2'd3; // dtack low until strobe ends

	logic               as_s;     // registered address strobe, active high
	logic [1:0]         state;
	logic               rtc_sel;  // cyc/stb to the clock port
	logic               cfg_sel;  // cyc/stb to the config block
	logic               miss_ack; // stands in for a slave ack
	logic [`DATA_W-1:0] data_q;   // held cpu read data
	logic               dtack_q;  // active high dtack
	logic [`WIN_W-1:0]  win;
	logic               rtc_hit;
	logic               cfg_hit;
	logic               any_ack;

	// --------------------
	// window decode
	assign win     = cpu_address[`ADDR_W -: `WIN_W]; // bits 23..16
	assign rtc_hit = cpu_r_w && (win == `RTC_WIN);   // reads only
	assign cfg_hit = cpu_r_w && (win == `CFG_WIN);
	assign any_ack = rtc_bus.ack | cfg_bus.ack | miss_ack;

	// slave links
	assign rtc_bus.cyc = rtc_sel;
	assign rtc_bus.stb = rtc_sel;
	assign rtc_bus.adr = cpu_address; // stable for the whole cycle
	assign cfg_bus.cyc = cfg_sel;
	assign cfg_bus.stb = cfg_sel;
	assign cfg_bus.adr = cpu_address;

	// --------------------
	// cycle sequencer
	always_ff @(posedge clk) begin
		if (reset) begin
			as_s     <= 1'b0;
			state    <= ST_IDLE;
			rtc_sel  <= 1'b0;
			cfg_sel  <= 1'b0;
			miss_ack <= 1'b0;
			dtack_q  <= 1'b0;
			data_q   <= '0;
		end else begin
			as_s     <= ~cpu_as_n; // edge N samples strobe low
			miss_ack <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (as_s) begin // edge N+1
						rtc_sel <= rtc_hit;
						cfg_sel <= cfg_hit;
						state   <= (rtc_hit | cfg_hit) ? ST_WAIT : ST_MISS;
					end
				end
				ST_MISS: begin // edge N+2, same slot as a slave ack
					miss_ack <= 1'b1;
					state    <= ST_WAIT;
				end
				ST_WAIT: begin
					if (any_ack) begin // edge N+3
						rtc_sel <= 1'b0;
						cfg_sel <= 1'b0;
						data_q  <= rtc_bus.dat_r | cfg_bus.dat_r; // idle slaves give zero
						dtack_q <= 1'b1;
						state   <= ST_HOLD;
					end
				end
				ST_HOLD: begin
					if (!as_s) begin // strobe seen high on the edge before
						dtack_q <= 1'b0;
						data_q  <= '0;
						state   <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign cpu_data    = data_q;
	assign cpu_dtack_n = ~dtack_q;

	// level 7 override from the cartridge side
	assign cpu_ipl_n = int7 ? 3'b000 : ipl_n;

	// only one slave may answer a cycle
	a_one_ack: assert property (@(posedge clk) disable iff (reset)
		!(rtc_bus.ack && cfg_bus.ack));

endmodule

/* cpu_bus_if.sv */
// point to point link from the cpu bus front end to one register slave
// subset of wishbone classic with read data only
// the front holds cyc and stb until ack, the slave acks for one cycle
// dat_r is zero outside ack so several slaves can be or-ed
`timescale 1ns/1ns
`include "minimig_glue_settings.svh"

interface cpu_bus_if;

	logic                cyc;   // cycle in progress
	logic                stb;   // strobe for this slave
	logic [`ADDR_W:1]    adr;   // m68k word address bits
	logic [`DATA_W-1:0]  dat_r; // read data valid with ack
	logic                ack;   // single cycle acknowledge

	// bus front end side
	modport front (
		output cyc, stb, adr,
		input  dat_r, ack
	);

	// register slave side
	modport slave (
		input  cyc, stb, adr,
		output dat_r, ack
	);

endinterface

/* host_config.sv */
// host loaded configuration block and its cpu readback slave
// host words arrive on io_strobe while io_ena is high
// the first word is a command, OP_CFG_WRITE takes one data word after it
// further words in the same io_ena window are ignored
// the ntsc flag only follows the chipset word while sys_reset is high
`timescale 1ns/1ns
`include "minimig_glue_settings.svh"

module host_config (
	input  logic               clk,
	input  logic               reset,
	input  logic               sys_reset,
	input  logic               io_ena,
	input  logic               io_strobe,
	input  logic [`DATA_W-1:0] io_din,
	input  logic               ovl,
	input  logic               cpu_custom,
	cpu_bus_if.slave           bus,
	output logic [5:0]         memcfg,
	output logic               turbochipram,
	output logic               turbokick,
	output logic               ntsc,
	output logic               usr_reset,
	output logic               cpu_hold
);

	// register widths
	localparam int MEM_W  = 7; // memory config
	localparam int CHIP_W = 5; // chipset config
	localparam int CPU_W  = 4; // cpu config

	// host decoder states
	localparam logic [1:0] HS_CMD  = 2'd0; // next word is a command
	localparam logic [1:0] HS_DATA = 2'd1; // next word is config data
	localparam logic [1:0] HS_DONE = 2'd2; // skip until io_ena drops

	minimig_pkg::host_word_u host_w;
	logic [1:0]              hstate;
	logic [7:0]              idx_q;   // target of a pending write
	logic [MEM_W-1:0]        mem_cfg;
	logic [CHIP_W-1:0]       chip_cfg;
	logic [CPU_W-1:0]        cpu_cfg;
	logic [`DATA_W-1:0]      rd_word; // readback mux
	logic                    req;

	assign host_w = io_din;

	// --------------------
	// host command receiver
	always_ff @(posedge clk) begin
		if (reset) begin
			hstate    <= HS_CMD;
			idx_q     <= '0;
			mem_cfg   <= '0;
			chip_cfg  <= '0;
			cpu_cfg   <= '0;
			usr_reset <= 1'b0;
			cpu_hold  <= 1'b0;
		end else begin
			usr_reset <= 1'b0; // single cycle pulse
			if (!io_ena) begin
				hstate <= HS_CMD; // rearm for the next transfer
			end else if (io_strobe) begin
				case (hstate)
					HS_CMD: begin
						hstate <= HS_DONE;
						case (host_w.cmd.opcode)
							`OP_CFG_WRITE: begin
								idx_q  <= host_w.cmd.index;
								hstate <= HS_DATA;
							end
							`OP_USER_RESET: usr_reset <= 1'b1;
							`OP_CPU_HOLD:   cpu_hold  <= host_w.cmd.index[0];
							default: ; // unknown opcode dropped
						endcase
					end
					HS_DATA: begin
						hstate <= HS_DONE;
						case (idx_q)
							8'd0: mem_cfg  <= host_w.raw[MEM_W-1:0];
							8'd1: chip_cfg <= host_w.raw[CHIP_W-1:0];
							8'd2: cpu_cfg  <= host_w.raw[CPU_W-1:0];
							default: ; // index past CFG_REGS
						endcase
					end
					default: ;
				endcase
			end
		end
	end

	// --------------------
	// cpu readback, word offset k gives register k
	always_comb begin
		rd_word = '0;
		case (bus.adr[2:1])
			2'd0: rd_word[MEM_W-1:0]  = mem_cfg;
			2'd1: rd_word[CHIP_W-1:0] = chip_cfg;
			2'd2: rd_word[CPU_W-1:0]  = cpu_cfg;
			default: ; // offset 3 reads zero
		endcase
	end

	assign req = bus.cyc & bus.stb & ~bus.ack;

	always_ff @(posedge clk) begin
		if (reset) begin
			bus.ack   <= 1'b0;
			bus.dat_r <= '0;
		end else begin
			bus.ack   <= req;
			bus.dat_r <= req ? rd_word : '0;
		end
	end

	// --------------------
	// derived flags
	// fast chip needs aga, no overlay, fast chip or agnus idle, and 2 MB chip
	assign turbochipram = chip_cfg[4] & ~ovl & (cpu_cfg[2] | cpu_custom) & (&mem_cfg[1:0]);
	assign turbokick    = ~ovl & (cpu_cfg[3] | chip_cfg[4]);
	assign memcfg       = mem_cfg[5:0];

	// video standard switches only across a system reset
	always_ff @(posedge clk) begin
		if (reset) begin
			ntsc <= 1'b0;
		end else if (sys_reset) begin
			ntsc <= chip_cfg[1];
		end
	end

	// host strobes only inside an io_ena window
	a_strobe_in_ena: assert property (@(posedge clk) disable iff (reset)
		io_strobe |-> io_ena);

endmodule

/* minimig_glue.f */
+incdir+.
minimig_pkg.sv
cpu_bus_if.sv
cpu_bus_front.sv
rtc_port.sv
host_config.sv
reset_control.sv
minimig_glue.sv
tb_minimig_glue.sv

/* minimig_glue.sv */
// cpu side glue around the chip set
// m68k bus in, dtack and read data out, cpu writes have no effect
// clock value, host channel and reset sources come from the board controller
`timescale 1ns/1ns
`include "minimig_glue_settings.svh"

module minimig_glue (
	input  logic                clk,
	input  logic                reset,
	// m68k bus
	input  logic [`ADDR_W:1]    cpu_address,
	input  logic                cpu_as_n,
	input  logic                cpu_r_w,
	output logic [`DATA_W-1:0]  cpu_data,
	output logic                cpu_dtack_n,
	input  logic [2:0]          ipl_n,
	input  logic                int7,
	output logic [2:0]          cpu_ipl_n,
	output logic                cpu_reset_n,
	// host side
	input  logic [`RTC_W-1:0]   rtc,
	input  logic                io_ena,
	input  logic                io_strobe,
	input  logic [`DATA_W-1:0]  io_din,
	// chip set status
	input  logic                ovl,
	input  logic                cpu_custom,
	input  logic                sof,
	output logic [5:0]          memcfg,
	output logic                turbochipram,
	output logic                turbokick,
	output logic                ntsc,
	// reset sources
	input  logic                kbd_reset,
	input  logic                rst_ext,
	input  logic                cpu_reset_req_n,
	output logic                rst_out
);

	logic usr_reset; // host user reset pulse
	logic cpu_hold;  // host cpu hold level

	cpu_bus_if rtc_bus ();
	cpu_bus_if cfg_bus ();

	cpu_bus_front u_front (
		.clk         (clk),
		.reset       (reset),
		.cpu_address (cpu_address),
		.cpu_as_n    (cpu_as_n),
		.cpu_r_w     (cpu_r_w),
		.cpu_data    (cpu_data),
		.cpu_dtack_n (cpu_dtack_n),
		.ipl_n       (ipl_n),
		.int7        (int7),
		.cpu_ipl_n   (cpu_ipl_n),
		.rtc_bus     (rtc_bus),
		.cfg_bus     (cfg_bus)
	);

	rtc_port u_rtc (
		.clk   (clk),
		.reset (reset),
		.rtc   (rtc),
		.bus   (rtc_bus)
	);

	host_config u_cfg (
		.clk          (clk),
		.reset        (reset),
		.sys_reset    (rst_out),
		.io_ena       (io_ena),
		.io_strobe    (io_strobe),
		.io_din       (io_din),
		.ovl          (ovl),
		.cpu_custom   (cpu_custom),
		.bus          (cfg_bus),
		.memcfg       (memcfg),
		.turbochipram (turbochipram),
		.turbokick    (turbokick),
		.ntsc         (ntsc),
		.usr_reset    (usr_reset),
		.cpu_hold     (cpu_hold)
	);

	reset_control u_rst (
		.clk             (clk),
		.reset           (reset),
		.kbd_reset       (kbd_reset),
		.usr_reset       (usr_reset),
		.rst_ext         (rst_ext),
		.cpu_reset_req_n (cpu_reset_req_n),
		.sof             (sof),
		.cpu_hold        (cpu_hold),
		.sys_reset       (rst_out), // system reset status out
		.cpu_reset_n     (cpu_reset_n)
	);

endmodule

/* minimig_glue_settings.svh */
// widths, address windows and host opcodes for the cpu glue
// windows compare cpu address bits 23..16 only so each one covers 64 KB
// host opcodes sit in the upper byte of a command word
`ifndef MINIMIG_GLUE_SETTINGS_SVH
`define MINIMIG_GLUE_SETTINGS_SVH

// bus widths
`define DATA_W 16 // cpu and host data word
`define ADDR_W 23 // m68k word address, bits 23..1
`define RTC_W  64 // packed clock value from the host

// --------------------
// address windows
`define WIN_W   8     // upper address bits compared
`define RTC_WIN 8'hDC // 0xDC0000 clock port
`define CFG_WIN 8'hDE // 0xDE0000 config readback

// config block
`define CFG_REGS 3 // memory, chipset, cpu

// --------------------
// host channel opcodes
`define OP_CFG_WRITE  8'h10 // index picks the register, data word follows
`define OP_USER_RESET 8'h11 // no data word
`define OP_CPU_HOLD   8'h12 // index bit 0 is the hold level

`define RESET_HOLD_FRAMES 2 // sof pulses after the last reset request

`endif

/* minimig_pkg.sv */
// types shared by the glue logic
// one host word is read either as a command or as plain data
// the decoder picks the view from its own state and not from the word
`include "minimig_glue_settings.svh"

package minimig_pkg;

	// --------------------
	// host channel word
	// first word after io_ena rises uses the cmd view
	// a following data word uses the raw view
	typedef union packed {
		struct packed {
			logic [7:0] opcode; // upper byte
			logic [7:0] index;  // register number or flag bits
		} cmd;
		logic [`DATA_W-1:0] raw; // data payload
	} host_word_u;

endpackage

/* reset_control.sv */
// system reset merge and frame counted release
// requests are asynchronous to clk and pass two synchronizer flops
// sys_reset releases on the RESET_HOLD_FRAMES-th sof after the request ends
// sof must be a single cycle pulse per frame
`timescale 1ns/1ns
`include "minimig_glue_settings.svh"

module reset_control (
	input  logic clk,
	input  logic reset,
	input  logic kbd_reset,
	input  logic usr_reset,
	input  logic rst_ext,
	input  logic cpu_reset_req_n,
	input  logic sof,
	input  logic cpu_hold,
	output logic sys_reset,
	output logic cpu_reset_n
);

	localparam int CNT_W = $clog2(`RESET_HOLD_FRAMES + 1);

	logic             req;    // merged request
	logic             req_s1; // synchronizer stage 1
	logic             req_s2; // synchronizer stage 2
	logic             hold_q; // frame hold after release
	logic [CNT_W-1:0] frames; // sof pulses seen since release

	assign req = kbd_reset | usr_reset | rst_ext | ~cpu_reset_req_n;

	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			req_s1 <= 1'b0;
			req_s2 <= 1'b0;
			hold_q <= 1'b1; // come up in system reset
			frames <= '0;
		end else begin
			req_s1 <= req;
			req_s2 <= req_s1;
			if (req_s2) begin
				hold_q <= 1'b1; // restart the count while requested
				frames <= '0;
			end else if (hold_q && sof) begin
				frames <= frames + 1'b1;
				if (frames == CNT_W'(`RESET_HOLD_FRAMES - 1)) begin
					hold_q <= 1'b0; // last frame seen
				end
			end
		end
	end

	assign sys_reset   = req_s2 | hold_q;
	assign cpu_reset_n = ~(sys_reset | cpu_hold); // host may hold the cpu alone

	// system reset only ends on a frame boundary
	a_release_on_sof: assert property (@(posedge clk) disable iff (reset)
		$fell(sys_reset) |-> $past(sof));

endmodule

/* rtc_port.sv */
// read port for the 64-bit clock value from the host
// byte address bits 5..2 pick one of sixteen nibbles
// nibble 0 is rtc[3:0], the rest of the word reads zero
`timescale 1ns/1ns
`include "minimig_glue_settings.svh"

module rtc_port (
	input  logic             clk,
	input  logic             reset,
	input  logic [`RTC_W-1:0] rtc,
	cpu_bus_if.slave         bus
);

	logic       req;    // first cycle of a strobe
	logic [3:0] nibble; // selected clock digit

	assign req    = bus.cyc & bus.stb & ~bus.ack; // front holds stb until ack
	assign nibble = rtc[{bus.adr[5:2], 2'b00} +: 4];

	// --------------------
	// ack one cycle after stb rises
	always_ff @(posedge clk) begin
		if (reset) begin
			bus.ack   <= 1'b0;
			bus.dat_r <= '0;
		end else begin
			bus.ack <= req;
			if (req) begin
				bus.dat_r <= {{(`DATA_W-4){1'b0}}, nibble}; // zero padded
			end else begin
				bus.dat_r <= '0; // zero outside ack for the or-ed bus
			end
		end
	end

endmodule

/* tb_minimig_glue.sv */
// testbench for the cpu glue, random stimulus checked against a local model
// inputs change 1 ns after the rising edge, outputs are sampled there too
// combinational outputs are sampled 1 ns after their inputs change
// the run stops at the first mismatch
`timescale 1ns/1ns
`include "minimig_glue_settings.svh"

module tb_minimig_glue;

	// model copies of the timing rules
	localparam int DTACK_CYC   = 3;  // strobe sampled low to dtack low
	localparam int HOLD_FRAMES = 2;  // sof pulses after a reset request ends
	localparam int WAIT_LIMIT  = 16; // cycles before a handshake is lost
	// per test cycle budgets
	localparam int N_RTC    = 40;
	localparam int N_CFG    = 20;
	localparam int N_FLAG   = 20;
	localparam int N_MISC   = 30;
	localparam int N_RST    = 12;
	localparam int READ_CYC = 12; // one bus cycle with slack
	localparam int HOST_CYC = 4;
	localparam int BUDGET   = 40 + N_RTC * READ_CYC + N_CFG * (HOST_CYC + 3 * READ_CYC)
		+ N_FLAG * (3 * HOST_CYC + 2) + N_MISC * (2 * READ_CYC + 2) + N_RST * 80 + 20;
	localparam int WATCHDOG_NS = (BUDGET + 200) * 8;

	logic clk, reset, cpu_as_n, cpu_r_w, cpu_dtack_n, int7, cpu_reset_n;
	logic io_ena, io_strobe, ovl, cpu_custom, sof, turbochipram, turbokick, ntsc;
	logic kbd_reset, rst_ext, cpu_reset_req_n, rst_out;
	logic [`ADDR_W:1]   cpu_address;
	logic [`DATA_W-1:0] cpu_data, io_din;
	logic [2:0]         ipl_n, cpu_ipl_n;
	logic [`RTC_W-1:0]  rtc;
	logic [5:0]         memcfg;

	// model state
	logic [6:0] mem_m;  // memory config
	logic [4:0] chip_m; // chipset config
	logic [3:0] cpu_m;  // cpu config
	integer     seed = 36946;
	int         errors = 0;
	logic [`ADDR_W:1]   addr;
	logic [`DATA_W-1:0] data;
	int         k, src;
	logic       ntsc_exp; // chipset bit 1 as it was during reset

	minimig_glue u_dut (.*);

	always #4 clk = ~clk; // 8 ns period

	// --------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "%s", why);
	endtask

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			abort_run("stopping at the first mismatch");
		end
	endtask

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	task automatic next_edge(); // lands 1 ns after the rising edge
		@(posedge clk);
		#1;
	endtask

	// one m68k cycle, strobe low until dtack, then wait for dtack to clear
	task automatic bus_cycle(input logic [`ADDR_W:1] a, input logic rw,
			output logic [`DATA_W-1:0] d);
		int lat;
		next_edge();
		cpu_address = a;
		cpu_r_w     = rw;
		cpu_as_n    = 1'b0;
		next_edge(); // edge N samples the strobe
		lat = 0;
		while (cpu_dtack_n !== 1'b0 && lat < WAIT_LIMIT) begin
			next_edge();
			lat++;
		end
		if (cpu_dtack_n !== 1'b0)
			abort_run("cpu_dtack_n never fell during a bus cycle");
		check("cpu_dtack_n delay", lat, DTACK_CYC);
		d        = cpu_data;
		cpu_as_n = 1'b1;
		lat      = 0;
		while (cpu_dtack_n !== 1'b1 && lat < WAIT_LIMIT) begin
			next_edge();
			lat++;
		end
		if (cpu_dtack_n !== 1'b1)
			abort_run("cpu_dtack_n stayed low after the strobe ended");
	endtask

	// single command word, returns just after the edge that took it
	task automatic host_cmd(input logic [7:0] op, input logic [7:0] idx);
		next_edge();
		io_ena    = 1'b1;
		io_strobe = 1'b1;
		io_din    = {op, idx};
		next_edge();
		io_strobe = 1'b0;
		io_ena    = 1'b0;
	endtask

	task automatic host_cfg_write(input int idx, input logic [`DATA_W-1:0] d);
		next_edge();
		io_ena    = 1'b1;
		io_strobe = 1'b1;
		io_din    = {8'(`OP_CFG_WRITE), 8'(idx)};
		next_edge();
		io_din = d; // data word right behind the command
		next_edge();
		io_strobe = 1'b0;
		io_ena    = 1'b0;
		case (idx)
			0: mem_m  = d[6:0];
			1: chip_m = d[4:0];
			2: cpu_m  = d[3:0];
			default: ; // past the config block, dropped
		endcase
	endtask

	function automatic logic [`DATA_W-1:0] model_word(input int r);
		case (r)
			0: return 16'(mem_m);
			1: return 16'(chip_m);
			2: return 16'(cpu_m);
			default: return 16'h0;
		endcase
	endfunction

	task automatic pulse_sof();
		next_edge();
		sof = 1'b1;
		next_edge();
		sof = 1'b0;
	endtask

	// sof pulses with random gaps, rst_out drops only after the last one
	task automatic release_frames();
		for (int f = 1; f <= HOLD_FRAMES; f++) begin
			repeat (3 + rand_below(4)) begin
				next_edge();
				check("rst_out", rst_out, 1);
			end
			pulse_sof();
			check("rst_out", rst_out, (f < HOLD_FRAMES) ? 1 : 0);
		end
	endtask

	task automatic set_source(input int s, input logic on);
		case (s)
			0: kbd_reset = on;
			2: rst_ext = on;
			3: cpu_reset_req_n = ~on; // active low request
			default: ; // user reset is a host pulse
		endcase
	endtask

	// --------------------
	initial begin
		clk             = 1'b0;
		reset           = 1'b1;
		cpu_address     = '0;
		cpu_as_n        = 1'b1;
		cpu_r_w         = 1'b1;
		ipl_n           = 3'b111;
		int7            = 1'b0;
		rtc             = '0;
		io_ena          = 1'b0;
		io_strobe       = 1'b0;
		io_din          = '0;
		ovl             = 1'b0;
		cpu_custom      = 1'b0;
		sof             = 1'b0;
		kbd_reset       = 1'b0;
		rst_ext         = 1'b0;
		cpu_reset_req_n = 1'b1;
		mem_m           = '0;
		chip_m          = '0;
		cpu_m           = '0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		check("rst_out", rst_out, 1); // system reset after power up
		check("cpu_reset_n", cpu_reset_n, 0);
		release_frames();
		check("cpu_reset_n", cpu_reset_n, 1);

		// rtc nibbles
		for (int i = 0; i < N_RTC; i++) begin
			rtc       = {$random(seed), $random(seed)};
			k         = rand_below(16);
			addr      = {`RTC_WIN, 15'($random(seed))};
			addr[5:2] = k[3:0]; // byte address bits 5..2
			bus_cycle(addr, 1'b1, data);
			check("cpu_data", data, (rtc >> (4 * k)) & 64'hF);
		end

		// host writes, cpu readback
		for (int i = 0; i < N_CFG; i++) begin
			host_cfg_write(rand_below(4), $random(seed));
			for (int r = 0; r < 3; r++) begin
				bus_cycle({`CFG_WIN, 15'(r)}, 1'b1, data); // word offset r
				check("cpu_data", data, model_word(r));
			end
			check("memcfg", memcfg, mem_m[5:0]);
		end

		// derived flags
		for (int i = 0; i < N_FLAG; i++) begin
			for (int r = 0; r < 3; r++)
				host_cfg_write(r, $random(seed));
			next_edge();
			ovl        = $random(seed);
			cpu_custom = $random(seed);
			#1;
			check("turbochipram", turbochipram,
				chip_m[4] & ~ovl & (cpu_m[2] | cpu_custom) & mem_m[1] & mem_m[0]);
			check("turbokick", turbokick, ~ovl & (cpu_m[3] | chip_m[4]));
		end
		ovl = 1'b0;

		// unmapped reads, writes, ipl override
		for (int i = 0; i < N_MISC; i++) begin
			addr = $random(seed);
			while (addr[23:16] == `RTC_WIN || addr[23:16] == `CFG_WIN)
				addr[23:16] = $random(seed);
			bus_cycle(addr, 1'b1, data);
			check("cpu_data", data, 0);
			bus_cycle($random(seed), 1'b0, data); // write anywhere
			check("cpu_data", data, 0);
			ipl_n = $random(seed);
			int7  = $random(seed);
			#1;
			check("cpu_ipl_n", cpu_ipl_n, int7 ? 3'b000 : ipl_n);
		end
		int7 = 1'b0;

		// --------------------
		// reset sources and ntsc latch
		for (int i = 0; i < N_RST; i++) begin
			host_cfg_write(1, $random(seed)); // new chipset word
			ntsc_exp = chip_m[1];
			src      = rand_below(4);
			if (src == 1) begin
				host_cmd(`OP_USER_RESET, 8'($random(seed))); // pulse on this edge
			end else begin
				next_edge();
				set_source(src, 1'b1);
			end
			next_edge();
			check("rst_out", rst_out, 0); // still in the synchronizer
			next_edge();
			check("rst_out", rst_out, 1);
			check("cpu_reset_n", cpu_reset_n, 0);
			repeat (rand_below(4)) next_edge();
			set_source(src, 1'b0);
			release_frames();
			check("ntsc", ntsc, ntsc_exp);
			host_cfg_write(1, {chip_m[4:2], ~chip_m[1], chip_m[0]});
			check("ntsc", ntsc, ntsc_exp); // latch holds outside reset
		end

		// cpu hold from the host
		check("cpu_reset_n", cpu_reset_n, 1);
		host_cmd(`OP_CPU_HOLD, 8'($random(seed)) | 8'h01);
		check("cpu_reset_n", cpu_reset_n, 0);
		repeat (2 + rand_below(6)) begin
			next_edge();
			check("cpu_reset_n", cpu_reset_n, 0);
			check("rst_out", rst_out, 0); // cpu held alone
		end
		host_cmd(`OP_CPU_HOLD, 8'($random(seed)) & 8'hFE);
		check("cpu_reset_n", cpu_reset_n, 1);

		if (errors == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			abort_run("errors were counted during the run");
		end
	end

	// watchdog over the summed budgets
	initial begin
		#(WATCHDOG_NS);
		abort_run("watchdog expired before the tests finished");
	end

endmodule
